// File: Makefile
# Verilator build and run of the instrument core testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_top
LOG       ?= sim.log
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep '\.sv$$' $(FLIST)) $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "no pass status in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+hw
hw/rp_pkg.sv
hw/analog_if.sv
hw/sys_bus_decoder.sv
hw/hk_regs.sv
hw/p_regulator.sv
hw/dac_mixer.sv
hw/rp_top.sv
bench/tb_rp_top.sv

// File: bench/tb_rp_top.sv
//----------------------------------------------------------------------
// testbench of the instrument core
// clock and reset, bus master tasks, reference model of the
// sample path, compare tasks, pin compare process, test sequence
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module tb_rp_top
  import rp_pkg::*;
;

  localparam int S_MAX = (1 << (`RP_ADC_W - 1)) - 1;  // 8191
  localparam int S_MIN = -(1 << (`RP_ADC_W - 1));     // -8192

  logic                 adc_clk;
  logic                 rst_n_i;
  logic [`RP_ADC_W-1:0] adc_dat_a;
  logic [`RP_ADC_W-1:0] adc_dat_b;
  logic [`RP_ADC_W-1:0] dac_dat_a;
  logic [`RP_ADC_W-1:0] dac_dat_b;
  logic [7:0]           led;
  sys_req_t             sys_req;
  sys_rsp_t             sys_rsp;

  // model of what was written into the DUT
  int         raw   [2];
  int         m_sp  [2];
  int         m_kp  [2];
  int         m_lvl [2];
  logic [1:0] m_en;

  event cmp_ev;            // starts one pin compare
  int   cmp_req_cnt  = 0;  // written by the sequence only
  int   cmp_done_cnt = 0;  // written by the compare process only

  rp_top UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .led_o       (led),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  //--------------------------------------------------------------------
  // error reporting and compare tasks

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [`RP_DATA_W-1:0] got,
                            input logic [`RP_DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_rsp(input string name, input sys_rsp_t got, input sys_rsp_t exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_dac(input string name, input logic [`RP_ADC_W-1:0] got,
                           input logic [`RP_ADC_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  //--------------------------------------------------------------------
  // reference model of the sample path

  function automatic int clamp_sample(input int v);
    if (v > S_MAX) return S_MAX;
    if (v < S_MIN) return S_MIN;
    return v;
  endfunction

  function automatic logic [`RP_ADC_W-1:0] dac_expect(input int raw_w, input int sp,
      input int kp, input bit en, input int lvl);
    int adc;
    int pid;
    int sum;
    adc = S_MAX - raw_w;                            // negative slope, mid code 8191
    pid = ((sp - adc) * kp) >>> `RP_KP_SHIFT;       // floor of product / 128
    pid = en ? clamp_sample(pid) : 0;
    sum = clamp_sample(lvl + pid);
    return `RP_ADC_W'(S_MAX - sum);                 // pin code, zero at 0x1fff
  endfunction

  function automatic logic [31:0] reg_addr(input int region, input int off);
    return (32'(region) << `RP_REGION_LSB) | (32'(off) << 2);
  endfunction

  function automatic int rand_sample();
    return int'($urandom % 32'd16384) + S_MIN;
  endfunction

  function automatic int rand_gain();
    return int'($urandom % 32'd256) - 128;
  endfunction

  //--------------------------------------------------------------------
  // bus master

  task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic wr, output sys_rsp_t rsp);
    int cyc;
    @(negedge adc_clk);
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = !wr;
    rsp = '0;
    cyc = 0;
    while (!rsp.ack) begin
      @(negedge adc_clk);
      rsp         = sys_rsp;   // stable since the last rising edge
      sys_req.wen = 1'b0;      // strobes last one cycle
      sys_req.ren = 1'b0;
      cyc++;
      if (!rsp.ack && cyc >= 20)
        abort_run($sformatf("timeout: no bus ack within 20 cycles at address 0x%h", addr));
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    sys_rsp_t rsp;
    bus_cycle(addr, wdata, 1'b1, rsp);
    if (rsp.err)
      abort_run($sformatf("bus write to 0x%h returned an error", addr));
  endtask

  task automatic bus_read(input logic [31:0] addr, output sys_rsp_t rsp);
    bus_cycle(addr, '0, 1'b0, rsp);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
    sys_rsp_t rsp;
    bus_read(addr, rsp);
    check_rsp(name, rsp, '{rdata: exp, err: 1'b0, ack: 1'b1});
  endtask

  task automatic write_expect(input string name, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp);
    sys_rsp_t rsp;
    bus_cycle(addr, wdata, 1'b1, rsp);
    check_rsp(name, rsp, '{rdata: exp, err: 1'b0, ack: 1'b1});
  endtask

  //--------------------------------------------------------------------
  // stimulus helpers, keep the model in step

  task automatic set_adc(input int ra, input int rb);
    @(negedge adc_clk);
    raw[0]    = ra;
    raw[1]    = rb;
    adc_dat_a = `RP_ADC_W'(ra);
    adc_dat_b = `RP_ADC_W'(rb);
  endtask

  task automatic write_pid(input int sp_a, input int sp_b, input int kp_a,
                           input int kp_b, input logic [1:0] en);
    bus_write(reg_addr(REG_PID, PID_SP_A), sp_a);
    bus_write(reg_addr(REG_PID, PID_SP_B), sp_b);
    bus_write(reg_addr(REG_PID, PID_KP_A), kp_a);
    bus_write(reg_addr(REG_PID, PID_KP_B), kp_b);
    bus_write(reg_addr(REG_PID, PID_EN), {30'd0, en});
    m_sp[0] = sp_a;
    m_sp[1] = sp_b;
    m_kp[0] = kp_a;
    m_kp[1] = kp_b;
    m_en    = en;
  endtask

  task automatic write_levels(input int la, input int lb);
    bus_write(reg_addr(REG_MIX, MIX_LVL_A), la);
    bus_write(reg_addr(REG_MIX, MIX_LVL_B), lb);
    m_lvl[0] = la;
    m_lvl[1] = lb;
  endtask

  //--------------------------------------------------------------------
  // pin compare, 8 cycles settle then 4 cycles checked

  always @(cmp_ev) begin : pin_compare
    repeat (8) @(negedge adc_clk);
    for (int k = 0; k < 4; k++) begin
      check_dac("dac_dat_a_o", dac_dat_a,
                dac_expect(raw[0], m_sp[0], m_kp[0], m_en[0], m_lvl[0]));
      check_dac("dac_dat_b_o", dac_dat_b,
                dac_expect(raw[1], m_sp[1], m_kp[1], m_en[1], m_lvl[1]));
      @(negedge adc_clk);
    end
    cmp_done_cnt = cmp_done_cnt + 1;
  end

  task automatic settle_and_compare();
    int wait_cnt;
    cmp_req_cnt = cmp_req_cnt + 1;
    -> cmp_ev;
    wait_cnt = 0;
    while (cmp_done_cnt != cmp_req_cnt) begin
      @(negedge adc_clk);
      wait_cnt++;
      if (wait_cnt > 30)
        abort_run("timeout: pin compare did not complete within 30 cycles");
    end
  endtask

  //--------------------------------------------------------------------
  // test sequence

  initial begin : sequence_main
    int v;
    rst_n_i   = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    sys_req   = '0;
    raw       = '{default: 0};
    m_sp      = '{default: 0};
    m_kp      = '{default: 0};
    m_lvl     = '{default: 0};
    m_en      = 2'b00;
    void'($urandom(26087));
    repeat (10) @(negedge adc_clk);
    rst_n_i = 1'b1;

    // reset state, id word, led register
    check_dac("dac_dat_a_o", dac_dat_a, 14'h1fff);
    check_dac("dac_dat_b_o", dac_dat_b, 14'h1fff);
    check_word("led_o", {24'd0, led}, 32'd0);
    read_expect("hk id", reg_addr(REG_HK, HK_ID), `RP_HK_ID);
    v = int'($urandom);
    bus_write(reg_addr(REG_HK, HK_LED), v);
    check_word("led_o", {24'd0, led}, v & 32'hff);
    read_expect("hk led", reg_addr(REG_HK, HK_LED), v & 32'hff);
    settle_and_compare();

    // empty region and undecoded offsets
    read_expect("region 5 read", reg_addr(5, 0), 32'd0);
    write_expect("region 5 write", reg_addr(5, 1), 32'hdeadbeef, 32'd0);
    read_expect("hk offset 5", reg_addr(REG_HK, 5), 32'd0);
    read_expect("pid offset 7", reg_addr(REG_PID, 7), 32'd0);
    read_expect("mix offset 3", reg_addr(REG_MIX, 3), 32'd0);

    // levels alone with the regulator off
    for (int t = 0; t < 5; t++) begin
      write_levels(rand_sample(), rand_sample());
      read_expect("mix lvl a", reg_addr(REG_MIX, MIX_LVL_A), m_lvl[0]);
      read_expect("mix lvl b", reg_addr(REG_MIX, MIX_LVL_B), m_lvl[1]);
      settle_and_compare();
    end

    // random trials, both channels on
    for (int t = 0; t < 50; t++) begin
      set_adc(int'($urandom % 32'd16384), int'($urandom % 32'd16384));
      write_pid(rand_sample(), rand_sample(), rand_gain(), rand_gain(), 2'b11);
      write_levels(rand_sample(), rand_sample());
      settle_and_compare();
    end
    read_expect("pid en", reg_addr(REG_PID, PID_EN), 32'd3);
    read_expect("pid sp a", reg_addr(REG_PID, PID_SP_A), m_sp[0]);
    read_expect("pid kp b", reg_addr(REG_PID, PID_KP_B), m_kp[1]);

    // clamps: regulator pos/neg, then mixer sum pos/neg
    set_adc(16383, 0);  // ch a at -8192, ch b at +8191
    write_pid(S_MAX, S_MIN, 127, 127, 2'b11);
    write_levels(0, 0);
    settle_and_compare();
    write_levels(S_MAX, S_MIN);
    settle_and_compare();
    set_adc(0, 16383);
    write_pid(S_MIN, S_MAX, 127, 127, 2'b11);
    write_levels(0, 0);
    settle_and_compare();
    write_levels(S_MIN, S_MAX);
    settle_and_compare();

    // only channel a enabled, b shows its level
    for (int t = 0; t < 5; t++) begin
      set_adc(int'($urandom % 32'd16384), int'($urandom % 32'd16384));
      write_pid(rand_sample(), rand_sample(), rand_gain(), rand_gain(), 2'b01);
      write_levels(rand_sample(), rand_sample());
      settle_and_compare();
      check_dac("dac_dat_b_o", dac_dat_b, `RP_ADC_W'(S_MAX - m_lvl[1]));
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/analog_if.sv
//----------------------------------------------------------------------
// analog front end
// adc input registers with unsigned neg-slope to two's complement,
// dac output registers with the reverse coding
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module analog_if
  import rp_pkg::*;
(
  input  wire logic                adc_clk,
  input  wire logic                rst_n_i,
  // converter pins
  input  wire logic [`RP_ADC_W-1:0] adc_dat_a_i,  // raw adc ch a
  input  wire logic [`RP_ADC_W-1:0] adc_dat_b_i,  // raw adc ch b
  output logic      [`RP_ADC_W-1:0] dac_dat_a_o,  // coded dac ch a
  output logic      [`RP_ADC_W-1:0] dac_dat_b_o,  // coded dac ch b
  // fabric side
  output sample_t                  adc_a_o,      // two's complement
  output sample_t                  adc_b_o,
  input  sample_t                  dac_a_i,      // from mixer
  input  sample_t                  dac_b_i
);

  // dac code of a zero sample, msb kept, rest inverted
  localparam logic [`RP_ADC_W-1:0] DAC_ZERO = {1'b0, {(`RP_ADC_W-1){1'b1}}};

  //--------------------------------------------------------------------
  // adc side

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= {adc_dat_a_i[`RP_ADC_W-1], ~adc_dat_a_i[`RP_ADC_W-2:0]};  // flip slope
      adc_b_o <= {adc_dat_b_i[`RP_ADC_W-1], ~adc_dat_b_i[`RP_ADC_W-2:0]};
    end
  end

  //--------------------------------------------------------------------
  // dac side

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_dat_a_o <= DAC_ZERO;  // pins idle at mid code
      dac_dat_b_o <= DAC_ZERO;
    end else begin
      dac_dat_a_o <= {dac_a_i[`RP_ADC_W-1], ~dac_a_i[`RP_ADC_W-2:0]};  // back to pin coding
      dac_dat_b_o <= {dac_b_i[`RP_ADC_W-1], ~dac_b_i[`RP_ADC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

// File: hw/dac_mixer.sv
//----------------------------------------------------------------------
// dac mixer
// programmable dc level per channel, saturating sum with
// the regulator output, level registers on the bus
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module dac_mixer
  import rp_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic rst_n_i,
  input  sys_req_t  sys_req_i,
  output sys_rsp_t  sys_rsp_o,
  input  sample_t   pid_a_i,   // regulator output
  input  sample_t   pid_b_i,
  output sample_t   mix_a_o,   // to dac coding
  output sample_t   mix_b_o
);

  localparam int SUM_W = `RP_ADC_W + 1;

  rp_reg_e                 offset;
  sample_t                 lvl    [2];  // dc levels
  sample_t                 pid_in [2];
  logic signed [SUM_W-1:0] sum    [2];
  sample_t                 mix_q  [2];
  logic [`RP_DATA_W-1:0]   rd_data;
  logic [`RP_DATA_W-1:0]   rdata_q;
  logic                    ack_q;

  assign offset    = sys_req_i.addr[5:2];
  assign pid_in[0] = pid_a_i;
  assign pid_in[1] = pid_b_i;
  assign mix_a_o   = mix_q[0];
  assign mix_b_o   = mix_q[1];

  //--------------------------------------------------------------------
  // level registers and bus reply

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lvl <= '{default: '0};
    end else if (sys_req_i.wen) begin
      case (offset)
        MIX_LVL_A: lvl[0] <= sys_req_i.wdata[`RP_ADC_W-1:0];
        MIX_LVL_B: lvl[1] <= sys_req_i.wdata[`RP_ADC_W-1:0];
        default:   ;
      endcase
    end
  end

  always_comb begin
    case (offset)
      MIX_LVL_A: rd_data = {{(`RP_DATA_W-`RP_ADC_W){lvl[0][`RP_ADC_W-1]}}, lvl[0]};
      MIX_LVL_B: rd_data = {{(`RP_DATA_W-`RP_ADC_W){lvl[1][`RP_ADC_W-1]}}, lvl[1]};
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen || sys_req_i.ren;
    end
  end

  always_ff @(posedge adc_clk) begin
    rdata_q <= rd_data;
  end

  assign sys_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

  //--------------------------------------------------------------------
  // sum with saturation on the two top bits

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mix_q <= '{default: '0};
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (sum[i][SUM_W-1:SUM_W-2])
          2'b01:   mix_q[i] <= {1'b0, {(`RP_ADC_W-1){1'b1}}};  // pos. overflow
          2'b10:   mix_q[i] <= {1'b1, {(`RP_ADC_W-1){1'b0}}};  // neg. overflow
          default: mix_q[i] <= sum[i][`RP_ADC_W-1:0];
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      sum[i] = SUM_W'(lvl[i]) + SUM_W'(pid_in[i]);  // 15-bit signed
    end
  end

endmodule

`default_nettype wire

// File: hw/hk_regs.sv
//----------------------------------------------------------------------
// housekeeping registers
// read-only id word and the led register, registered bus reply
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module hk_regs
  import rp_pkg::*;
(
  input  wire logic       adc_clk,
  input  wire logic       rst_n_i,
  input  sys_req_t        sys_req_i,  // gated by decoder
  output sys_rsp_t        sys_rsp_o,
  output logic      [7:0] led_o       // board leds
);

  rp_reg_e               offset;
  logic [`RP_DATA_W-1:0] rd_data;
  logic [`RP_DATA_W-1:0] rdata_q;
  logic                  ack_q;

  assign offset = sys_req_i.addr[5:2];  // word offset

  //--------------------------------------------------------------------
  // register writes

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      led_o <= '0;
    end else if (sys_req_i.wen && (offset == HK_LED)) begin
      led_o <= sys_req_i.wdata[7:0];  // low byte only
    end
  end

  //--------------------------------------------------------------------
  // read mux and reply

  always_comb begin
    case (offset)
      HK_ID:   rd_data = `RP_HK_ID;
      HK_LED:  rd_data = {{(`RP_DATA_W-8){1'b0}}, led_o};  // zero-extended
      default: rd_data = '0;                                // undecoded offset
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen || sys_req_i.ren;  // one cycle after strobe
    end
  end

  always_ff @(posedge adc_clk) begin
    rdata_q <= rd_data;  // sampled while addr is held
  end

  assign sys_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

endmodule

`default_nettype wire

// File: hw/p_regulator.sv
//----------------------------------------------------------------------
// two-channel proportional regulator
// setpoint, gain and enable registers on the bus,
// error stage and scaled, saturated product stage per channel
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module p_regulator
  import rp_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic rst_n_i,
  input  sys_req_t  sys_req_i,
  output sys_rsp_t  sys_rsp_o,
  input  sample_t   adc_a_i,    // measured value
  input  sample_t   adc_b_i,
  output sample_t   pid_a_o,    // regulator output
  output sample_t   pid_b_o
);

  localparam int ERR_W  = `RP_ADC_W + 1;  // setpoint minus sample
  localparam int PROD_W = ERR_W + 8;      // error times 8-bit gain

  rp_reg_e                  offset;
  logic [1:0]               en;            // bit 0 ch a, bit 1 ch b
  sample_t                  sp      [2];   // setpoints
  logic signed [7:0]        kp      [2];   // gains
  sample_t                  adc_in  [2];
  logic signed [ERR_W-1:0]  err_q   [2];   // stage one
  logic signed [PROD_W-1:0] prod    [2];
  logic signed [PROD_W-1:0] prod_sh [2];
  sample_t                  sat     [2];
  sample_t                  out_q   [2];   // stage two
  logic [`RP_DATA_W-1:0]    rd_data;
  logic [`RP_DATA_W-1:0]    rdata_q;
  logic                     ack_q;

  assign offset    = sys_req_i.addr[5:2];
  assign adc_in[0] = adc_a_i;
  assign adc_in[1] = adc_b_i;
  assign pid_a_o   = out_q[0];
  assign pid_b_o   = out_q[1];

  //--------------------------------------------------------------------
  // register bank

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en <= '0;
      sp <= '{default: '0};
      kp <= '{default: '0};
    end else if (sys_req_i.wen) begin
      case (offset)
        PID_EN:   en    <= sys_req_i.wdata[1:0];
        PID_SP_A: sp[0] <= sys_req_i.wdata[`RP_ADC_W-1:0];
        PID_SP_B: sp[1] <= sys_req_i.wdata[`RP_ADC_W-1:0];
        PID_KP_A: kp[0] <= sys_req_i.wdata[7:0];
        PID_KP_B: kp[1] <= sys_req_i.wdata[7:0];
        default:  ;  // write ignored
      endcase
    end
  end

  always_comb begin
    case (offset)
      PID_EN:   rd_data = {{(`RP_DATA_W-2){1'b0}}, en};
      PID_SP_A: rd_data = {{(`RP_DATA_W-`RP_ADC_W){sp[0][`RP_ADC_W-1]}}, sp[0]};
      PID_SP_B: rd_data = {{(`RP_DATA_W-`RP_ADC_W){sp[1][`RP_ADC_W-1]}}, sp[1]};
      PID_KP_A: rd_data = {{(`RP_DATA_W-8){kp[0][7]}}, kp[0]};
      PID_KP_B: rd_data = {{(`RP_DATA_W-8){kp[1][7]}}, kp[1]};
      default:  rd_data = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen || sys_req_i.ren;
    end
  end

  always_ff @(posedge adc_clk) begin
    rdata_q <= rd_data;
  end

  assign sys_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

  //--------------------------------------------------------------------
  // datapath, product scaled down then clamped to 14 bits

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      prod[i]    = PROD_W'(err_q[i]) * PROD_W'(kp[i]);  // signed, full width
      prod_sh[i] = prod[i] >>> `RP_KP_SHIFT;
      if (!prod_sh[i][PROD_W-1] && (|prod_sh[i][PROD_W-2:`RP_ADC_W-1]))
        sat[i] = {1'b0, {(`RP_ADC_W-1){1'b1}}};   // pos. overflow
      else if (prod_sh[i][PROD_W-1] && !(&prod_sh[i][PROD_W-2:`RP_ADC_W-1]))
        sat[i] = {1'b1, {(`RP_ADC_W-1){1'b0}}};   // neg. overflow
      else
        sat[i] = prod_sh[i][`RP_ADC_W-1:0];
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= '{default: '0};
      out_q <= '{default: '0};
    end else begin
      for (int i = 0; i < 2; i++) begin
        err_q[i] <= ERR_W'(sp[i]) - ERR_W'(adc_in[i]);  // sign-extended diff
        out_q[i] <= en[i] ? sat[i] : '0;                // disabled gives 0
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rp_config.svh
//----------------------------------------------------------------------
// global widths and constants of the instrument core
// converter and bus widths, region field, regulator shift, id word
//----------------------------------------------------------------------

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

`define RP_ADC_W       14             // converter word width
`define RP_DATA_W      32             // system bus data width

`define RP_REGION_LSB  20             // region field starts at addr[20]
`define RP_REGION_W    3              // 8 regions, addr[22:20]

`define RP_KP_SHIFT    7              // product scaling, kp of 128 is unity

`define RP_HK_ID       32'h52500001   // read-only id in housekeeping

`endif

// File: hw/rp_pkg.sv
//----------------------------------------------------------------------
// shared types of the instrument core
// bus request and response structs, sample type,
// region enum and register word offsets
//----------------------------------------------------------------------

`default_nettype none

`include "rp_config.svh"

package rp_pkg;

  // two's complement sample as used inside the fabric
  typedef logic signed [`RP_ADC_W-1:0] sample_t;

  typedef struct packed {
    logic [31:0]           addr;   // byte address
    logic [`RP_DATA_W-1:0] wdata;  // write data
    logic                  wen;    // write strobe, one cycle
    logic                  ren;    // read strobe, one cycle
  } sys_req_t;

  typedef struct packed {
    logic [`RP_DATA_W-1:0] rdata;  // valid with ack
    logic                  err;    // always low here
    logic                  ack;    // one cycle
  } sys_rsp_t;

  // address space split on addr[22:20]
  typedef enum logic [`RP_REGION_W-1:0] {
    REG_HK  = 3'd0,  // housekeeping
    REG_MIX = 3'd2,  // dc level mixer
    REG_PID = 3'd3   // proportional regulator
  } rp_region_e;

  // word offsets from addr[5:2], each region reuses the same range
  typedef logic [3:0] rp_reg_e;

  localparam rp_reg_e HK_ID     = 4'd0;
  localparam rp_reg_e HK_LED    = 4'd1;

  localparam rp_reg_e PID_EN    = 4'd0;
  localparam rp_reg_e PID_SP_A  = 4'd1;
  localparam rp_reg_e PID_SP_B  = 4'd2;
  localparam rp_reg_e PID_KP_A  = 4'd3;
  localparam rp_reg_e PID_KP_B  = 4'd4;

  localparam rp_reg_e MIX_LVL_A = 4'd0;
  localparam rp_reg_e MIX_LVL_B = 4'd1;

endpackage

`default_nettype wire

// File: hw/rp_top.sv
//----------------------------------------------------------------------
// top level of the instrument core
// front end, bus decoder, housekeeping, regulator and mixer
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module rp_top
  import rp_pkg::*;
(
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  input  wire logic [`RP_ADC_W-1:0] adc_dat_a_i,  // raw adc words
  input  wire logic [`RP_ADC_W-1:0] adc_dat_b_i,
  output logic      [`RP_ADC_W-1:0] dac_dat_a_o,  // coded dac words
  output logic      [`RP_ADC_W-1:0] dac_dat_b_o,
  output logic      [7:0]           led_o,
  input  sys_req_t                  sys_req_i,    // bus master side
  output sys_rsp_t                  sys_rsp_o
);

  sample_t  adc_a, adc_b;  // converted samples
  sample_t  pid_a, pid_b;  // regulator out
  sample_t  mix_a, mix_b;  // mixer out
  sys_req_t hk_req, mix_req, pid_req;
  sys_rsp_t hk_rsp, mix_rsp, pid_rsp;

  //--------------------------------------------------------------------
  // analog front end

  analog_if i_analog (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_a_i     (mix_a),
    .dac_b_i     (mix_b)
  );

  //--------------------------------------------------------------------
  // bus and slaves

  sys_bus_decoder i_dec (
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp),
    .mix_req_o (mix_req),
    .mix_rsp_i (mix_rsp),
    .pid_req_o (pid_req),
    .pid_rsp_i (pid_rsp)
  );

  hk_regs i_hk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (hk_req),
    .sys_rsp_o (hk_rsp),
    .led_o     (led_o)
  );

  p_regulator i_pid (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (pid_req),
    .sys_rsp_o (pid_rsp),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .pid_a_o   (pid_a),
    .pid_b_o   (pid_b)
  );

  dac_mixer i_mix (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (mix_req),
    .sys_rsp_o (mix_rsp),
    .pid_a_i   (pid_a),
    .pid_b_i   (pid_b),
    .mix_a_o   (mix_a),
    .mix_b_o   (mix_b)
  );

endmodule

`default_nettype wire

// File: hw/sys_bus_decoder.sv
//----------------------------------------------------------------------
// system bus decoder
// region decode on addr[22:20], strobe routing to the slaves,
// response multiplexer with a fixed reply for empty regions
//----------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rp_config.svh"

module sys_bus_decoder
  import rp_pkg::*;
(
  input  sys_req_t sys_req_i,  // from bus master
  output sys_rsp_t sys_rsp_o,
  // slave ports
  output sys_req_t hk_req_o,
  input  sys_rsp_t hk_rsp_i,
  output sys_req_t mix_req_o,
  input  sys_rsp_t mix_rsp_i,
  output sys_req_t pid_req_o,
  input  sys_rsp_t pid_rsp_i
);

  // empty regions answer at once, no error, zero data
  localparam sys_rsp_t RSP_EMPTY = '{rdata: '0, err: 1'b0, ack: 1'b1};

  rp_region_e region;

  assign region = rp_region_e'(sys_req_i.addr[`RP_REGION_LSB +: `RP_REGION_W]);

  //--------------------------------------------------------------------
  // request routing, addr and wdata pass to everyone

  always_comb begin
    hk_req_o      = sys_req_i;
    mix_req_o     = sys_req_i;
    pid_req_o     = sys_req_i;
    hk_req_o.wen  = sys_req_i.wen && (region == REG_HK);   // gate strobes
    hk_req_o.ren  = sys_req_i.ren && (region == REG_HK);
    mix_req_o.wen = sys_req_i.wen && (region == REG_MIX);
    mix_req_o.ren = sys_req_i.ren && (region == REG_MIX);
    pid_req_o.wen = sys_req_i.wen && (region == REG_PID);
    pid_req_o.ren = sys_req_i.ren && (region == REG_PID);
  end

  //--------------------------------------------------------------------
  // response select on the current address

  always_comb begin
    case (region)
      REG_HK:  sys_rsp_o = hk_rsp_i;
      REG_MIX: sys_rsp_o = mix_rsp_i;
      REG_PID: sys_rsp_o = pid_rsp_i;
      default: sys_rsp_o = RSP_EMPTY;  // regions 1, 4..7
    endcase
  end

endmodule

`default_nettype wire
